// ==== list.f ====
src/ls_pkg.sv
src/ls_ctrl.sv
src/lsu.sv
src/clint.sv
src/ls_stage.sv
tests/tb_ls_stage.sv

// ==== Bender.yml ====
package:
  name: ls_stage

sources:
  - src/ls_pkg.sv
  - src/ls_ctrl.sv
  - src/lsu.sv
  - src/clint.sv
  - src/ls_stage.sv
  - target: test
    files:
      - tests/tb_ls_stage.sv

// ==== tests/tb_ls_stage.sv ====
`timescale 1ns/1ns

module tb_ls_stage import ls_pkg::*; ();

    typedef struct packed {
        logic [1:0]  kind;     // 0 alu, 1 load, 2 store.
        logic [31:0] instr;
        logic [31:0] last;
        logic [63:0] addr;
        logic [63:0] rs2;
        logic [63:0] wb;
        logic        hold;
        logic [63:0] exp;      // load result, or the store data before the lane shift.
        logic [7:0]  mask;
    } row_t;

    localparam logic [31:0] NOP = 32'h0000_0013;

    logic clk, rst_n_i, stall_n, timed_out;
    logic [31:0] instr, instr_last;
    logic [63:0] addr, rs2, wb_data, ls_res, clint_rdata;
    logic ls_not_ok, timer_int;
    sram_req_t sram_req;
    sram_rsp_t sram_rsp;
    clint_req_t clint_req;
    logic [63:0] mem [8];
    logic busy;
    logic [1:0] delay_cnt;
    int req_count, errors, tests, failed;
    row_t rows[$];

    ls_stage i_dut (
        .clk(clk), .rst_n_i(rst_n_i), .instr_i(instr), .instr_last_i(instr_last),
        .addr_i(addr), .rs2_i(rs2), .wb_data_i(wb_data), .stall_n_i(stall_n),
        .sram_rsp_i(sram_rsp), .clint_req_i(clint_req), .ls_res_o(ls_res),
        .ls_not_ok_o(ls_not_ok), .sram_req_o(sram_req), .clint_rdata_o(clint_rdata),
        .timer_int_o(timer_int)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    ////////////////////////////////////////
    // sram model
    ////////////////////////////////////////

    always @(posedge clk) begin
        sram_rsp <= '0;
        if (!rst_n_i) begin
            busy <= 1'b0;
        end else if (busy) begin
            if (delay_cnt == 2'd0) begin
                busy <= 1'b0;
                if (sram_req.wr_en) begin
                    for (int k = 0; k < 8; k++)
                        if (sram_req.wr_mask[k])
                            mem[sram_req.addr[5:3]][8*k +: 8] <= sram_req.wr_data[8*k +: 8];
                    sram_rsp.wr_ok <= 1'b1;
                end else begin
                    sram_rsp.rd_valid <= 1'b1;
                    sram_rsp.rd_data  <= mem[sram_req.addr[5:3]];
                end
            end else begin
                delay_cnt <= delay_cnt - 1'b1;
            end
        end else if ((sram_req.rd_en | sram_req.wr_en) &&
                     !(sram_rsp.rd_valid | sram_rsp.wr_ok)) begin
            busy      <= 1'b1;                     // a new access starts here.
            delay_cnt <= 2'($urandom % 4);
            req_count <= req_count + 1;
        end
    end

    function automatic logic [31:0] ld_instr(input logic [2:0] f3, input logic [4:0] rd);
        return {12'h000, 5'd1, f3, rd, 7'b0000011};
    endfunction

    function automatic logic [31:0] st_instr(input logic [2:0] f3, input logic [4:0] rs2_idx);
        return {7'h00, rs2_idx, 5'd1, f3, 5'd0, 7'b0100011};
    endfunction

    // the merge the SRAM should perform under the byte mask.
    function automatic logic [63:0] merge_word(input logic [63:0] prev, input logic [63:0] data,
                                               input logic [2:0] off, input logic [7:0] mask);
        logic [63:0] shifted;
        logic [63:0] res;
        shifted = data << (8 * off);
        res     = prev;
        for (int k = 0; k < 8; k++)
            if (mask[k]) res[8*k +: 8] = shifted[8*k +: 8];
        return res;
    endfunction

    task automatic check_val(input logic [63:0] got, input logic [63:0] exp, input string msg);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %h expected %h", $time, msg, got, exp);
            errors++;
        end
    endtask

    task automatic add_row(input logic [1:0] kind, input logic [31:0] ins, input logic [31:0] last,
                           input logic [63:0] a, input logic [63:0] r2, input logic [63:0] w,
                           input logic hold, input logic [63:0] exp, input logic [7:0] mask);
        rows.push_back('{kind, ins, last, a, r2, w, hold, exp, mask});
    endtask

    task automatic write_clint(input logic [15:0] a, input logic [63:0] d);
        @(posedge clk);
        clint_req <= '{valid: 1'b1, we: 1'b1, addr: a, wdata: d};
        @(posedge clk);
        clint_req <= '0;
    endtask

    task automatic read_clint(input logic [15:0] a, output logic [63:0] d);
        @(posedge clk);
        clint_req <= '{valid: 1'b1, we: 1'b0, addr: a, wdata: 64'd0};
        @(posedge clk);
        clint_req <= '0;
        @(negedge clk);
        d = clint_rdata;
    endtask

    task automatic run_row(input row_t r);
        logic [63:0] prev;
        int base;
        logic found;
        @(posedge clk);
        instr      <= r.instr;
        instr_last <= r.last;
        addr       <= r.addr;
        rs2        <= r.rs2;
        wb_data    <= r.wb;
        stall_n    <= !r.hold;
        prev  = mem[r.addr[5:3]];
        base  = req_count;
        found = 1'b0;
        if (r.kind == 2'd0) begin
            @(negedge clk);
            check_val(ls_res, r.addr, "alu result");
            check_val({sram_req.rd_en, sram_req.wr_en, ls_not_ok}, 3'b000, "alu enables");
            return;
        end
        for (int w = 0; w < 20 && !found; w++) begin
            @(negedge clk);
            if ((sram_rsp.rd_valid | sram_rsp.wr_ok) && !ls_not_ok) found = 1'b1;
        end
        if (!found) begin
            $display("timeout: no SRAM response for instruction %h", r.instr);
            timed_out = 1'b1;
            return;
        end
        // funct3 bits 1 to 0 give log2 of the access bytes.
        check_val(sram_req.addr, r.addr, "request address");
        check_val(sram_req.size, {1'b0, r.instr[13:12]}, "request size");
        if (r.kind == 2'd1) check_val(ls_res, r.exp, "load result");
        else check_val(sram_req.wr_mask, r.mask, "store mask");
        if (r.hold) begin
            repeat (3) begin
                @(negedge clk);
                check_val({sram_req.rd_en, sram_req.wr_en}, 2'b00, "enables while held");
                if (r.kind == 2'd1) check_val(ls_res, r.exp, "held load result");
            end
        end
        @(posedge clk);
        instr <= NOP;
        stall_n <= 1'b1;
        @(negedge clk);
        check_val(req_count - base, 1, "request count");
        if (r.kind == 2'd2)
            check_val(mem[r.addr[5:3]], merge_word(prev, r.exp, r.addr[2:0], r.mask),
                      "stored word");
    endtask

    initial begin
        logic [63:0] t1, t2, m;
        int err0, hit;
        void'($urandom(32'hdd310390));
        rst_n_i    = 1'b0;
        stall_n    = 1'b1;
        instr      = NOP;
        instr_last = NOP;
        addr       = '0;
        rs2        = '0;
        wb_data    = '0;
        sram_rsp   = '0;
        clint_req  = '0;
        req_count  = 0;
        errors     = 0;
        tests      = 0;
        failed     = 0;
        timed_out  = 1'b0;
        // byte at address a holds a, with bit 7 set on odd addresses.
        for (int i = 0; i < 8; i++)
            for (int k = 0; k < 8; k++)
                mem[i][8*k +: 8] = {k[0], 1'b0, i[2:0], k[2:0]};
        add_row(0, NOP, NOP, 64'h1234, 0, 0, 0, 0, 0);
        add_row(2, st_instr(F3_B, 5), NOP, 64'h03, 64'h1122334455667788, 0, 0,
                64'h1122334455667788, 8'h08);
        add_row(2, st_instr(F3_H, 5), NOP, 64'h0A, 64'h000000000000BEEF, 0, 0, 64'hBEEF, 8'h0C);
        add_row(2, st_instr(F3_W, 5), NOP, 64'h14, 64'h00000000DEADBEEF, 0, 1,
                64'hDEADBEEF, 8'hF0);
        add_row(2, st_instr(F3_D, 5), NOP, 64'h18, 64'h0123456789ABCDEF, 0, 0,
                64'h0123456789ABCDEF, 8'hFF);
        add_row(2, st_instr(F3_W, 7), ld_instr(F3_D, 7), 64'h20, 64'hAAAAAAAAAAAAAAAA,
                64'hCAFEF00D, 0, 64'hCAFEF00D, 8'h0F);
        add_row(2, st_instr(F3_B, 7), ld_instr(F3_D, 8), 64'h21, 64'h55, 64'hEE, 0, 64'h55, 8'h02);
        add_row(2, st_instr(F3_D, 0), ld_instr(F3_D, 0), 64'h28, 64'h1, 64'hFFFF, 0,
                64'h1, 8'hFF);
        add_row(1, ld_instr(F3_B, 3), NOP, 64'h31, 0, 0, 0, 64'hFFFFFFFFFFFFFFB1, 0);
        add_row(1, ld_instr(F3_B, 3), NOP, 64'h30, 0, 0, 0, 64'h30, 0);
        add_row(1, ld_instr(F3_BU, 3), NOP, 64'h33, 0, 0, 1, 64'hB3, 0);
        add_row(1, ld_instr(F3_H, 3), NOP, 64'h32, 0, 0, 0, 64'hFFFFFFFFFFFFB332, 0);
        add_row(1, ld_instr(F3_HU, 3), NOP, 64'h36, 0, 0, 0, 64'hB736, 0);
        add_row(1, ld_instr(F3_W, 3), NOP, 64'h34, 0, 0, 1, 64'hFFFFFFFFB736B534, 0);
        add_row(1, ld_instr(F3_WU, 3), NOP, 64'h30, 0, 0, 0, 64'hB332B130, 0);
        add_row(1, ld_instr(F3_D, 3), NOP, 64'h38, 0, 0, 0, 64'hBF3EBD3CBB3AB938, 0);
        add_row(1, ld_instr(F3_D, 3), NOP, 64'h18, 0, 0, 0, 64'h0123456789ABCDEF, 0);

        repeat (5) @(posedge clk);
        rst_n_i <= 1'b1;
        @(negedge clk);
        err0 = errors;
        check_val({sram_req.rd_en, sram_req.wr_en, ls_not_ok, timer_int}, 4'b0000, "reset state");
        check_val(clint_rdata, 64'd0, "reset read data");
        read_clint(CLINT_MTIMECMP_ADDR, t1);
        check_val(t1, '1, "reset mtimecmp");
        tests++;
        if (errors != err0) failed++;
        $display("test %0d reset: %s", tests, (errors == err0) ? "ok" : "FAIL");

        foreach (rows[i]) begin
            if (!timed_out) begin
                err0 = errors;
                run_row(rows[i]);
                tests++;
                if (errors != err0 || timed_out) failed++;
                $display("test %0d kind %0d at %h: %s", tests, rows[i].kind, rows[i].addr,
                         (errors == err0 && !timed_out) ? "ok" : "FAIL");
            end
        end

        ////////////////////////////////////////
        // timer
        ////////////////////////////////////////
        err0 = errors;
        read_clint(CLINT_MTIME_ADDR, t1);
        repeat (10) @(posedge clk);
        read_clint(CLINT_MTIME_ADDR, t2);
        check_val(t2 - t1, 64'd12, "mtime step");   // the valid cycles lie 12 apart.
        read_clint(CLINT_MTIME_ADDR, m);
        write_clint(CLINT_MTIMECMP_ADDR, m + 2 + 8);  // mtime is m+2 in the write cycle.
        hit = 0;
        for (int j = 1; j <= 12 && hit == 0; j++) begin
            @(negedge clk);
            if (timer_int) hit = j;
        end
        if (hit == 0) begin
            $display("timeout: timer interrupt never rose");
            errors++;
        end else begin
            check_val(hit >= 8 && hit <= 10, 1, "interrupt rise within 8 to 10 cycles");
        end
        write_clint(CLINT_MTIMECMP_ADDR, '1);
        repeat (2) @(posedge clk);
        @(negedge clk);
        check_val(timer_int, 1'b0, "interrupt clear");
        tests++;
        if (errors != err0) failed++;
        $display("test %0d clint: %s", tests, (errors == err0) ? "ok" : "FAIL");

        $display("tests %0d, failed %0d, check errors %0d", tests, failed, errors);
        if (errors == 0 && failed == 0 && !timed_out) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== src/ls_stage.sv ====
`timescale 1ns/1ns

module ls_stage import ls_pkg::*; (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic [INST_LEN-1:0] instr_i,
    input  logic [INST_LEN-1:0] instr_last_i,
    input  logic [XLEN-1:0]     addr_i,
    input  logic [XLEN-1:0]     rs2_i,
    input  logic [XLEN-1:0]     wb_data_i,
    input  logic                stall_n_i,
    input  sram_rsp_t           sram_rsp_i,
    input  clint_req_t          clint_req_i,

    output logic [XLEN-1:0]     ls_res_o,
    output logic                ls_not_ok_o,
    output sram_req_t           sram_req_o,
    output logic [XLEN-1:0]     clint_rdata_o,
    output logic                timer_int_o
);

    mem_op_t mem_op;

    ls_ctrl ls_ctrl_u (
        .instr_i      (instr_i),
        .instr_last_i (instr_last_i),
        .rs2_i        (rs2_i),
        .wb_data_i    (wb_data_i),
        .mem_op_o     (mem_op)
    );

    lsu lsu_u (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .mem_op_i     (mem_op),
        .addr_i       (addr_i),
        .stall_n_i    (stall_n_i),
        .sram_rsp_i   (sram_rsp_i),
        .sram_req_o   (sram_req_o),
        .ls_res_o     (ls_res_o),
        .ls_not_ok_o  (ls_not_ok_o)
    );

    // the timer sits beside the lsu and shares only clock and reset.
    clint clint_u (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .clint_req_i   (clint_req_i),
        .clint_rdata_o (clint_rdata_o),
        .timer_int_o   (timer_int_o)
    );

endmodule

// ==== src/clint.sv ====
`timescale 1ns/1ns

module clint import ls_pkg::*; (
    input  logic            clk,
    input  logic            rst_n_i,
    input  clint_req_t      clint_req_i,
    output logic [XLEN-1:0] clint_rdata_o,
    output logic            timer_int_o
);

    logic [XLEN-1:0] mtime_q;
    logic [XLEN-1:0] mtimecmp_q;
    logic            wr_mtime;
    logic            wr_mtimecmp;
    logic            rd_req;

    assign wr_mtime    = clint_req_i.valid & clint_req_i.we &
                         (clint_req_i.addr == CLINT_MTIME_ADDR);
    assign wr_mtimecmp = clint_req_i.valid & clint_req_i.we &
                         (clint_req_i.addr == CLINT_MTIMECMP_ADDR);
    assign rd_req      = clint_req_i.valid & ~clint_req_i.we;

    ////////////////////////////////////////
    // timer registers
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            mtime_q <= '0;
        end else if (wr_mtime) begin
            mtime_q <= clint_req_i.wdata;  // a write wins over the count.
        end else begin
            mtime_q <= mtime_q + 1'b1;
        end
    end

    // all ones keeps the interrupt quiet until software sets a compare value.
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            mtimecmp_q <= '1;
        end else if (wr_mtimecmp) begin
            mtimecmp_q <= clint_req_i.wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            clint_rdata_o <= '0;
        end else if (rd_req) begin
            case (clint_req_i.addr)
                CLINT_MTIME_ADDR:    clint_rdata_o <= mtime_q;
                CLINT_MTIMECMP_ADDR: clint_rdata_o <= mtimecmp_q;
                default:             clint_rdata_o <= '0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            timer_int_o <= 1'b0;
        end else begin
            timer_int_o <= (mtime_q >= mtimecmp_q);
        end
    end

endmodule

// ==== src/lsu.sv ====
`timescale 1ns/1ns

module lsu import ls_pkg::*; (
    input  logic            clk,
    input  logic            rst_n_i,
    input  mem_op_t         mem_op_i,
    input  logic [XLEN-1:0] addr_i,
    input  logic            stall_n_i,
    input  sram_rsp_t       sram_rsp_i,
    output sram_req_t       sram_req_o,
    output logic [XLEN-1:0] ls_res_o,
    output logic            ls_not_ok_o
);

    logic            done_q;
    logic [XLEN-1:0] ld_hold_q;
    logic            req_rd;
    logic            req_wr;
    logic            rsp_hit;
    logic [5:0]      lane_shift;
    logic [7:0]      base_mask;
    logic [XLEN-1:0] ld_shifted;
    logic            ld_msb;
    logic            ld_fill;
    logic [XLEN-1:0] ld_ext;

    ////////////////////////////////////////
    // request level and completion
    ////////////////////////////////////////

    // once the access has finished the same instruction must not go out again.
    assign req_rd  = mem_op_i.rd_en & ~done_q;
    assign req_wr  = mem_op_i.wr_en & ~done_q;
    assign rsp_hit = (req_rd & sram_rsp_i.rd_valid) | (req_wr & sram_rsp_i.wr_ok);

    assign ls_not_ok_o = (req_rd | req_wr) & ~rsp_hit;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            done_q <= 1'b0;
        end else if (stall_n_i) begin
            done_q <= 1'b0;               // the pipeline moves, a new op follows.
        end else if (rsp_hit) begin
            done_q <= 1'b1;
        end
    end

    ////////////////////////////////////////
    // store lane placement
    ////////////////////////////////////////

    assign lane_shift = {addr_i[2:0], 3'b000};

    always_comb begin
        case (mem_op_i.size)
            2'd0:    base_mask = 8'h01;
            2'd1:    base_mask = 8'h03;
            2'd2:    base_mask = 8'h0F;
            default: base_mask = 8'hFF;
        endcase
    end

    always_comb begin
        sram_req_o.rd_en   = req_rd;
        sram_req_o.wr_en   = req_wr;
        sram_req_o.addr    = addr_i;
        sram_req_o.wr_data = mem_op_i.wr_data << lane_shift;
        sram_req_o.wr_mask = base_mask << addr_i[2:0];
        sram_req_o.size    = {1'b0, mem_op_i.size};
    end

    ////////////////////////////////////////
    // load extraction and extension
    ////////////////////////////////////////

    assign ld_shifted = sram_rsp_i.rd_data >> lane_shift;

    always_comb begin
        case (mem_op_i.size)
            2'd0:    ld_msb = ld_shifted[7];
            2'd1:    ld_msb = ld_shifted[15];
            2'd2:    ld_msb = ld_shifted[31];
            default: ld_msb = ld_shifted[XLEN-1];
        endcase
    end

    assign ld_fill = ld_msb & ~mem_op_i.unsigned_ld;

    always_comb begin
        case (mem_op_i.size)
            2'd0:    ld_ext = {{(XLEN-8){ld_fill}}, ld_shifted[7:0]};
            2'd1:    ld_ext = {{(XLEN-16){ld_fill}}, ld_shifted[15:0]};
            2'd2:    ld_ext = {{(XLEN-32){ld_fill}}, ld_shifted[31:0]};
            default: ld_ext = ld_shifted;
        endcase
    end

    // keeps the loaded value while the op is held by a later stall.
    always_ff @(posedge clk) begin
        if (rsp_hit & req_rd) begin
            ld_hold_q <= ld_ext;
        end
    end

    always_comb begin
        if (mem_op_i.rd_en) begin
            ls_res_o = done_q ? ld_hold_q : ld_ext;
        end else begin
            ls_res_o = addr_i;            // non-load ops pass the ALU result on.
        end
    end

endmodule

// ==== src/ls_ctrl.sv ====
`timescale 1ns/1ns

module ls_ctrl import ls_pkg::*; (
    input  logic [INST_LEN-1:0] instr_i,
    input  logic [INST_LEN-1:0] instr_last_i,
    input  logic [XLEN-1:0]     rs2_i,
    input  logic [XLEN-1:0]     wb_data_i,
    output mem_op_t             mem_op_o
);

    logic [4:0] opcode;
    logic [2:0] funct3;
    logic [4:0] rs2_idx;
    logic [4:0] rd_last;
    logic       is_load;
    logic       is_store;
    logic       last_is_load;
    logic       fwd_hit;
    logic [1:0] size;
    logic       ld_unsigned;

    assign opcode   = instr_i[6:2];
    assign funct3   = instr_i[14:12];
    assign rs2_idx  = instr_i[24:20];
    assign rd_last  = instr_last_i[11:7];
    assign is_load  = (opcode == OPC_LOAD);
    assign is_store = (opcode == OPC_STORE);

    // the load now in write-back has not reached the register file yet.
    assign last_is_load = (instr_last_i[6:2] == OPC_LOAD);
    assign fwd_hit      = last_is_load & (rd_last != 5'd0) & (rd_last == rs2_idx);

    always_comb begin
        size        = 2'd0;
        ld_unsigned = 1'b0;
        case (funct3)
            F3_B:  size = 2'd0;
            F3_H:  size = 2'd1;
            F3_W:  size = 2'd2;
            F3_D:  size = 2'd3;
            F3_BU: begin
                size        = 2'd0;
                ld_unsigned = 1'b1;
            end
            F3_HU: begin
                size        = 2'd1;
                ld_unsigned = 1'b1;
            end
            F3_WU: begin
                size        = 2'd2;
                ld_unsigned = 1'b1;
            end
            default: size = 2'd3;
        endcase
    end

    always_comb begin
        mem_op_o.rd_en       = is_load;
        mem_op_o.wr_en       = is_store;
        mem_op_o.size        = size;
        mem_op_o.unsigned_ld = is_load & ld_unsigned;
        mem_op_o.wr_data     = fwd_hit ? wb_data_i : rs2_i;
    end

endmodule

// ==== src/ls_pkg.sv ====
package ls_pkg;

    ////////////////////////////////////////
    // widths, opcodes and funct3 codes
    ////////////////////////////////////////

    localparam int XLEN     = 64;
    localparam int INST_LEN = 32;

    // opcode field is instruction bits 6 to 2.
    localparam logic [4:0] OPC_LOAD  = 5'b00000;
    localparam logic [4:0] OPC_STORE = 5'b01000;

    localparam logic [2:0] F3_B  = 3'b000;
    localparam logic [2:0] F3_H  = 3'b001;
    localparam logic [2:0] F3_W  = 3'b010;
    localparam logic [2:0] F3_D  = 3'b011;
    localparam logic [2:0] F3_BU = 3'b100;
    localparam logic [2:0] F3_HU = 3'b101;
    localparam logic [2:0] F3_WU = 3'b110;

    localparam logic [15:0] CLINT_MTIMECMP_ADDR = 16'h4000;
    localparam logic [15:0] CLINT_MTIME_ADDR    = 16'hBFF8;

    ////////////////////////////////////////
    // bundles between the blocks
    ////////////////////////////////////////

    typedef struct packed {
        logic            rd_en;
        logic            wr_en;
        logic [1:0]      size;        // log2 of the access bytes.
        logic            unsigned_ld;
        logic [XLEN-1:0] wr_data;
    } mem_op_t;

    typedef struct packed {
        logic            rd_en;
        logic            wr_en;
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] wr_data;     // already placed in its byte lane.
        logic [7:0]      wr_mask;
        logic [2:0]      size;
    } sram_req_t;

    typedef struct packed {
        logic            rd_valid;
        logic            wr_ok;
        logic [XLEN-1:0] rd_data;
    } sram_rsp_t;

    typedef struct packed {
        logic            valid;
        logic            we;
        logic [15:0]     addr;
        logic [XLEN-1:0] wdata;
    } clint_req_t;

endpackage
